/* tests/rot_trace.txt */
# Columns (hex): op addr wdata exp_kind exp_val exp_resp
# op 0 read, 1 write, 2 random write; exp_kind 0 exp_val is rdata, 1 exp_val is LFSR word index
1 00000100 cafe0001 0 00000000 0
0 00000100 00000000 0 cafe0001 0
2 00000200 00000000 0 00000000 0
2 00000204 ffffffff 0 00000000 0
0 00000200 00000000 1 00000000 0
0 00000204 00000000 1 00000001 0
1 f0000010 12345678 0 00000000 2
0 f0000010 00000000 0 00000000 2
2 f0000020 00000000 0 00000000 2
2 00000208 00000000 0 00000000 0
0 00000208 00000000 1 00000003 0
1 effffffc 5a5a0f0f 0 00000000 0
0 effffffc 00000000 0 5a5a0f0f 0
0 fffffffc 00000000 0 00000000 2
1 00000300 11111111 0 00000000 0
1 00000304 22222222 0 00000000 0
1 00000300 33333333 0 00000000 0
0 00000304 00000000 0 22222222 0
0 00000300 00000000 0 33333333 0
2 0000030c 00000000 0 00000000 0
0 0000030c 00000000 1 00000004 0
0 00000100 00000000 0 cafe0001 0

/* files.f */
+incdir+verilog
verilog/rot_pkg.sv
verilog/cmd_intake.sv
verilog/entropy_lfsr.sv
verilog/axi_xfer_engine.sv
verilog/rsp_return.sv
verilog/rot_axi_wrap.sv
tests/tb_clkgen.sv
tests/tb_rot_axi_wrap.sv

/* Makefile */
TOP := tb_rot_axi_wrap

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -j 0 -Wno-fatal --timescale 1ns/10ps \
		--top-module $(TOP) -f files.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
		echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

/* tests/tb_rot_axi_wrap.sv */
// Reads tests/rot_trace.txt relative to the project root; run the simulation from there
`timescale 1ns/10ps
`include "rot_cfg.svh"

module tb_rot_axi_wrap import rot_pkg::*;;

   localparam int RST_TIMEOUT  = 64;
   localparam int ACK_TIMEOUT  = 1000;
   localparam int RSP_TIMEOUT  = 1000;
   localparam int DONE_TIMEOUT = 4000;

   // Exponent e of x^32 + x^22 + x^2 + x + 1 sits at bit e-1 of the right-shifting register
   localparam logic [31:0] POLY_MASK = (32'h1 << 31) | (32'h1 << 21) | (32'h1 << 1) | 32'h1;

   logic                   clk;
   logic                   rst_n;
   logic                   cmd_req_i;
   rot_op_e                cmd_op_i;
   logic [`ROT_ADDR_W-1:0] cmd_addr_i;
   logic [`ROT_DATA_W-1:0] cmd_wdata_i;
   logic                   cmd_ack_o;
   logic                   rsp_req_o;
   logic [`ROT_DATA_W-1:0] rsp_rdata_o;
   rot_resp_e              rsp_resp_o;
   logic                   rsp_ack_i;
   logic [`ROT_ADDR_W-1:0] aw_addr_o;
   logic                   aw_valid_o;
   logic                   aw_ready_i;
   logic [`ROT_DATA_W-1:0] w_data_o;
   logic [3:0]             w_strb_o;
   logic                   w_valid_o;
   logic                   w_ready_i;
   logic [1:0]             b_resp_i;
   logic                   b_valid_i;
   logic                   b_ready_o;
   logic [`ROT_ADDR_W-1:0] ar_addr_o;
   logic                   ar_valid_o;
   logic                   ar_ready_i;
   logic [`ROT_DATA_W-1:0] r_data_i;
   logic [1:0]             r_resp_i;
   logic                   r_valid_i;
   logic                   r_ready_o;

   // One entry per trace line
   logic [31:0] tr_op    [$];
   logic [31:0] tr_addr  [$];
   logic [31:0] tr_wdata [$];
   logic [31:0] tr_kind  [$];
   logic [31:0] tr_val   [$];
   logic [31:0] tr_resp  [$];

   logic [31:0] mem [logic [31:0]];
   integer      seed = 32'h72e5;
   int          rsp_done;

   tb_clkgen i_tb_clkgen (
      .clk_o   (clk),
      .rst_n_o (rst_n)
   );

   rot_axi_wrap i_rot_axi_wrap (
      .clk_i       (clk),
      .rst_n_i     (rst_n),
      .cmd_req_i   (cmd_req_i),
      .cmd_op_i    (cmd_op_i),
      .cmd_addr_i  (cmd_addr_i),
      .cmd_wdata_i (cmd_wdata_i),
      .cmd_ack_o   (cmd_ack_o),
      .rsp_req_o   (rsp_req_o),
      .rsp_rdata_o (rsp_rdata_o),
      .rsp_resp_o  (rsp_resp_o),
      .rsp_ack_i   (rsp_ack_i),
      .aw_addr_o   (aw_addr_o),
      .aw_valid_o  (aw_valid_o),
      .aw_ready_i  (aw_ready_i),
      .w_data_o    (w_data_o),
      .w_strb_o    (w_strb_o),
      .w_valid_o   (w_valid_o),
      .w_ready_i   (w_ready_i),
      .b_resp_i    (b_resp_i),
      .b_valid_i   (b_valid_i),
      .b_ready_o   (b_ready_o),
      .ar_addr_o   (ar_addr_o),
      .ar_valid_o  (ar_valid_o),
      .ar_ready_i  (ar_ready_i),
      .r_data_i    (r_data_i),
      .r_resp_i    (r_resp_i),
      .r_valid_i   (r_valid_i),
      .r_ready_o   (r_ready_o)
   );

   function automatic int rand_delay(input int span);
      logic [31:0] r;
      r = $random(seed);
      return int'(r % span);
   endfunction

   // Word 0 is the seed and word n follows after n shifts
   function automatic logic [31:0] lfsr_word(input int n);
      logic [31:0] s;
      int          k;
      s = `ROT_LFSR_SEED;
      for (k = 0; k < n; k++) begin
         if (s[0]) begin
            s = (s >> 1) ^ POLY_MASK;
         end else begin
            s = s >> 1;
         end
      end
      return s;
   endfunction

   // Unwritten locations read back a pattern tied to the full address
   function automatic logic [31:0] fill_word(input logic [31:0] addr);
      return {addr[15:0], addr[31:16]} ^ 32'hA5C3_3C5A;
   endfunction

   task automatic report_timeout(input string what);
      $display("TIMEOUT at %0t ns: %s", $time, what);
      $display("Simulation FAILED");
      $fatal(1, "wait loop timed out");
   endtask

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      if (got !== exp) begin
         $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         $display("Simulation FAILED");
         $fatal(1, "value check failed");
      end
   endtask

   task automatic read_trace();
      int          fd;
      int          n;
      string       line;
      logic [31:0] f_op;
      logic [31:0] f_addr;
      logic [31:0] f_wdata;
      logic [31:0] f_kind;
      logic [31:0] f_val;
      logic [31:0] f_resp;
      fd = $fopen("tests/rot_trace.txt", "r");
      if (fd == 0) begin
         $display("Could not open the trace file tests/rot_trace.txt");
         $display("Simulation FAILED");
         $fatal(1, "missing trace");
      end
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         // Skip comments and blank lines
         if (n > 1 && line.getc(0) != 8'h23) begin
            n = $sscanf(line, "%h %h %h %h %h %h", f_op, f_addr, f_wdata, f_kind, f_val, f_resp);
            if (n != 6) begin
               $display("Malformed trace line: %s", line);
               $display("Simulation FAILED");
               $fatal(1, "bad trace");
            end
            tr_op.push_back(f_op);
            tr_addr.push_back(f_addr);
            tr_wdata.push_back(f_wdata);
            tr_kind.push_back(f_kind);
            tr_val.push_back(f_val);
            tr_resp.push_back(f_resp);
         end
      end
      $fclose(fd);
   endtask

   task automatic check_idle_outputs();
      compare_value("cmd_ack_o", 32'(cmd_ack_o), 32'h0);
      compare_value("rsp_req_o", 32'(rsp_req_o), 32'h0);
      compare_value("aw_valid_o", 32'(aw_valid_o), 32'h0);
      compare_value("w_valid_o", 32'(w_valid_o), 32'h0);
      compare_value("ar_valid_o", 32'(ar_valid_o), 32'h0);
      compare_value("b_ready_o", 32'(b_ready_o), 32'h0);
      compare_value("r_ready_o", 32'(r_ready_o), 32'h0);
   endtask

   // Called on a falling edge and returns on one with req and ack low
   task automatic send_command(input int idx);
      int cycles;
      cmd_op_i    = rot_op_e'(tr_op[idx][1:0]);
      cmd_addr_i  = tr_addr[idx];
      cmd_wdata_i = tr_wdata[idx];
      cmd_req_i   = 1'b1;
      cycles = 0;
      while (cmd_ack_o !== 1'b1) begin
         @(negedge clk);
         cycles++;
         if (cycles > ACK_TIMEOUT) begin
            report_timeout($sformatf("command %0d was never acknowledged", idx));
         end
      end
      cmd_req_i = 1'b0;
      cycles = 0;
      while (cmd_ack_o !== 1'b0) begin
         @(negedge clk);
         cycles++;
         if (cycles > ACK_TIMEOUT) begin
            report_timeout($sformatf("command ack stayed high after command %0d", idx));
         end
      end
   endtask

   task automatic take_response(input int idx);
      int          cycles;
      int          delay;
      logic [31:0] exp_rdata;
      if (tr_kind[idx] == 32'h1) begin
         exp_rdata = lfsr_word(int'(tr_val[idx]));
      end else begin
         exp_rdata = tr_val[idx];
      end
      cycles = 0;
      while (rsp_req_o !== 1'b1) begin
         @(negedge clk);
         cycles++;
         if (cycles > RSP_TIMEOUT) begin
            report_timeout($sformatf("no response came for command %0d", idx));
         end
      end
      compare_value($sformatf("rsp_rdata_o (command %0d)", idx), rsp_rdata_o, exp_rdata);
      compare_value($sformatf("rsp_resp_o (command %0d)", idx), 32'(rsp_resp_o), tr_resp[idx]);
      // Slow host so the command FIFO fills up
      delay = rand_delay(16);
      repeat (delay) @(negedge clk);
      rsp_ack_i = 1'b1;
      cycles = 0;
      while (rsp_req_o !== 1'b0) begin
         @(negedge clk);
         cycles++;
         if (cycles > RSP_TIMEOUT) begin
            report_timeout($sformatf("response request stayed high for command %0d", idx));
         end
      end
      rsp_ack_i = 1'b0;
      rsp_done++;
   endtask

   initial begin : host_commands
      int idx;
      int cycles;
      cmd_req_i   = 1'b0;
      cmd_op_i    = OP_READ;
      cmd_addr_i  = '0;
      cmd_wdata_i = '0;
      read_trace();
      cycles = 0;
      while (rst_n !== 1'b1) begin
         @(negedge clk);
         cycles++;
         if (cycles > RST_TIMEOUT) begin
            report_timeout("reset was never released");
         end
      end
      @(negedge clk);
      check_idle_outputs();
      for (idx = 0; idx < tr_op.size(); idx++) begin
         send_command(idx);
      end
      cycles = 0;
      while (rsp_done < tr_op.size()) begin
         @(negedge clk);
         cycles++;
         if (cycles > DONE_TIMEOUT) begin
            report_timeout("not all responses came back");
         end
      end
      if (rsp_done == tr_op.size()) begin
         $display("Simulation PASSED");
         $finish;
      end else begin
         $display("Simulation FAILED");
         $fatal(1, "response count wrong");
      end
   end

   initial begin : host_responses
      int idx;
      int cycles;
      rsp_ack_i = 1'b0;
      rsp_done  = 0;
      cycles = 0;
      while (rst_n !== 1'b1) begin
         @(negedge clk);
         cycles++;
         if (cycles > RST_TIMEOUT) begin
            report_timeout("reset was never released");
         end
      end
      for (idx = 0; idx < tr_op.size(); idx++) begin
         take_response(idx);
      end
   end

   // AXI4-Lite slave memory; readies are raised only against a visible valid
   initial begin : axi_memory_model
      int          aw_wait;
      int          w_wait;
      int          ar_wait;
      int          b_wait;
      int          r_wait;
      logic        aw_have;
      logic        aw_acc;
      logic        w_have;
      logic        w_acc;
      logic        ar_have;
      logic        ar_acc;
      logic        b_fire;
      logic        r_fire;
      logic [31:0] aw_addr_s;
      logic [31:0] w_data_s;
      logic [31:0] ar_addr_s;
      aw_ready_i = 1'b0;
      w_ready_i  = 1'b0;
      ar_ready_i = 1'b0;
      b_valid_i  = 1'b0;
      b_resp_i   = 2'b00;
      r_valid_i  = 1'b0;
      r_resp_i   = 2'b00;
      r_data_i   = '0;
      forever begin
         @(negedge clk);
         if (!rst_n) begin
            aw_have = 1'b0;
            aw_acc  = 1'b0;
            w_have  = 1'b0;
            w_acc   = 1'b0;
            ar_have = 1'b0;
            ar_acc  = 1'b0;
            b_fire  = 1'b0;
            r_fire  = 1'b0;
            aw_wait = rand_delay(4);
            w_wait  = rand_delay(4);
            ar_wait = rand_delay(4);
            b_wait  = rand_delay(4);
            r_wait  = rand_delay(4);
         end else begin
            // Beats that completed on the last rising edge
            if (aw_ready_i) aw_acc = 1'b1;
            if (w_ready_i) w_acc = 1'b1;
            if (ar_ready_i) ar_acc = 1'b1;
            aw_ready_i = 1'b0;
            w_ready_i  = 1'b0;
            ar_ready_i = 1'b0;
            if (b_fire) begin
               b_valid_i = 1'b0;
               b_fire    = 1'b0;
               aw_have   = 1'b0;
               aw_acc    = 1'b0;
               w_have    = 1'b0;
               w_acc     = 1'b0;
               b_wait    = rand_delay(4);
            end
            if (r_fire) begin
               r_valid_i = 1'b0;
               r_fire    = 1'b0;
               ar_have   = 1'b0;
               ar_acc    = 1'b0;
               r_wait    = rand_delay(4);
            end
            if (aw_valid_o && !aw_have) begin
               if (aw_wait == 0) begin
                  aw_ready_i = 1'b1;
                  aw_have    = 1'b1;
                  aw_addr_s  = aw_addr_o;
                  aw_wait    = rand_delay(4);
               end else begin
                  aw_wait--;
               end
            end
            if (w_valid_o && !w_have) begin
               if (w_wait == 0) begin
                  // Every write covers all four byte lanes
                  compare_value("w_strb_o", 32'(w_strb_o), 32'hF);
                  w_ready_i = 1'b1;
                  w_have    = 1'b1;
                  w_data_s  = w_data_o;
                  w_wait    = rand_delay(4);
               end else begin
                  w_wait--;
               end
            end
            if (ar_valid_o && !ar_have) begin
               if (ar_wait == 0) begin
                  ar_ready_i = 1'b1;
                  ar_have    = 1'b1;
                  ar_addr_s  = ar_addr_o;
                  ar_wait    = rand_delay(4);
               end else begin
                  ar_wait--;
               end
            end
            // B only after both AW and W have been taken
            if (aw_acc && w_acc && !b_valid_i) begin
               if (b_wait == 0) begin
                  b_valid_i = 1'b1;
                  if (aw_addr_s >= `ROT_ERR_BASE) begin
                     b_resp_i = RESP_SLVERR;
                  end else begin
                     b_resp_i       = RESP_OKAY;
                     mem[aw_addr_s] = w_data_s;
                  end
               end else begin
                  b_wait--;
               end
            end
            if (ar_acc && !r_valid_i) begin
               if (r_wait == 0) begin
                  r_valid_i = 1'b1;
                  if (ar_addr_s >= `ROT_ERR_BASE) begin
                     // Junk data that the wrapper has to mask
                     r_resp_i = RESP_SLVERR;
                     r_data_i = 32'hDEAD_BEEF;
                  end else begin
                     r_resp_i = RESP_OKAY;
                     r_data_i = mem.exists(ar_addr_s) ? mem[ar_addr_s] : fill_word(ar_addr_s);
                  end
               end else begin
                  r_wait--;
               end
            end
            // Both high now means the beat moves on the next rising edge
            if (b_valid_i && b_ready_o) b_fire = 1'b1;
            if (r_valid_i && r_ready_o) r_fire = 1'b1;
         end
      end
   end

endmodule

/* tests/tb_clkgen.sv */
// Free-running 4 ns clock; reset is held low for 16 rising edges and released on a falling edge
`timescale 1ns/10ps

module tb_clkgen (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #2 clk_o = ~clk_o;
   end

   initial begin
      rst_n_o = 1'b0;
      repeat (16) @(posedge clk_o);
      @(negedge clk_o);
      rst_n_o = 1'b1;
   end

endmodule

/* verilog/rot_axi_wrap.sv */
// AXI4-Lite master only, one transaction outstanding and up to four commands in flight
`timescale 1ns/10ps
`include "rot_cfg.svh"

module rot_axi_wrap import rot_pkg::*; (
   input  logic                     clk_i,
   input  logic                     rst_n_i,
   // Host command link
   input  logic                     cmd_req_i,
   input  rot_op_e                  cmd_op_i,
   input  logic [`ROT_ADDR_W-1:0]   cmd_addr_i,
   input  logic [`ROT_DATA_W-1:0]   cmd_wdata_i,
   output logic                     cmd_ack_o,
   // Host response link
   output logic                     rsp_req_o,
   output logic [`ROT_DATA_W-1:0]   rsp_rdata_o,
   output rot_resp_e                rsp_resp_o,
   input  logic                     rsp_ack_i,
   // AXI AW channel
   output logic [`ROT_ADDR_W-1:0]   aw_addr_o,
   output logic                     aw_valid_o,
   input  logic                     aw_ready_i,
   // AXI W channel
   output logic [`ROT_DATA_W-1:0]   w_data_o,
   output logic [`ROT_DATA_W/8-1:0] w_strb_o,
   output logic                     w_valid_o,
   input  logic                     w_ready_i,
   // AXI B channel
   input  logic [1:0]               b_resp_i,
   input  logic                     b_valid_i,
   output logic                     b_ready_o,
   // AXI AR channel
   output logic [`ROT_ADDR_W-1:0]   ar_addr_o,
   output logic                     ar_valid_o,
   input  logic                     ar_ready_i,
   // AXI R channel
   input  logic [`ROT_DATA_W-1:0]   r_data_i,
   input  logic [1:0]               r_resp_i,
   input  logic                     r_valid_i,
   output logic                     r_ready_o
);

   logic                   cmd_valid;
   rot_op_e                cmd_op;
   logic [`ROT_ADDR_W-1:0] cmd_addr;
   logic [`ROT_DATA_W-1:0] cmd_wdata;
   logic                   cmd_pop;
   logic [`ROT_DATA_W-1:0] rnd_word;
   logic                   rnd_take;
   logic                   res_valid;
   logic [`ROT_DATA_W-1:0] res_rdata;
   rot_resp_e              res_resp;
   logic                   res_ready;

   cmd_intake u_cmd_intake (
      .clk_i,
      .rst_n_i,
      .cmd_req_i,
      .cmd_op_i,
      .cmd_addr_i,
      .cmd_wdata_i,
      .cmd_ack_o,
      .cmd_valid_o (cmd_valid),
      .cmd_op_o    (cmd_op),
      .cmd_addr_o  (cmd_addr),
      .cmd_wdata_o (cmd_wdata),
      .cmd_pop_i   (cmd_pop)
   );

   entropy_lfsr u_entropy_lfsr (
      .clk_i,
      .rst_n_i,
      .rnd_take_i (rnd_take),
      .rnd_word_o (rnd_word)
   );

   axi_xfer_engine u_axi_xfer_engine (
      .clk_i,
      .rst_n_i,
      .cmd_valid_i (cmd_valid),
      .cmd_op_i    (cmd_op),
      .cmd_addr_i  (cmd_addr),
      .cmd_wdata_i (cmd_wdata),
      .cmd_pop_o   (cmd_pop),
      .rnd_word_i  (rnd_word),
      .rnd_take_o  (rnd_take),
      .res_valid_o (res_valid),
      .res_rdata_o (res_rdata),
      .res_resp_o  (res_resp),
      .res_ready_i (res_ready),
      .aw_addr_o,
      .aw_valid_o,
      .aw_ready_i,
      .w_data_o,
      .w_strb_o,
      .w_valid_o,
      .w_ready_i,
      .b_resp_i,
      .b_valid_i,
      .b_ready_o,
      .ar_addr_o,
      .ar_valid_o,
      .ar_ready_i,
      .r_data_i,
      .r_resp_i,
      .r_valid_i,
      .r_ready_o
   );

   rsp_return u_rsp_return (
      .clk_i,
      .rst_n_i,
      .res_valid_i (res_valid),
      .res_rdata_i (res_rdata),
      .res_resp_i  (res_resp),
      .res_ready_o (res_ready),
      .rsp_req_o,
      .rsp_rdata_o,
      .rsp_resp_o,
      .rsp_ack_i
   );

endmodule

/* verilog/rsp_return.sv */
// Holds a single result; a new one is refused until the host has dropped rsp_ack_i
`timescale 1ns/10ps
`include "rot_cfg.svh"

module rsp_return import rot_pkg::*; (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  logic                   res_valid_i,
   input  logic [`ROT_DATA_W-1:0] res_rdata_i,
   input  rot_resp_e              res_resp_i,
   output logic                   res_ready_o,
   output logic                   rsp_req_o,
   output logic [`ROT_DATA_W-1:0] rsp_rdata_o,
   output rot_resp_e              rsp_resp_o,
   input  logic                   rsp_ack_i
);

   localparam logic [1:0] ST_EMPTY = 2'd0;
   localparam logic [1:0] ST_REQ   = 2'd1;
   localparam logic [1:0] ST_DROP  = 2'd2;

   logic [1:0]             state_q;
   logic [`ROT_DATA_W-1:0] rdata_q;
   rot_resp_e              resp_q;
   logic                   load;

   assign res_ready_o = (state_q == ST_EMPTY);
   assign load        = res_valid_i && res_ready_o;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q <= ST_EMPTY;
      end else begin
         case (state_q)
            ST_EMPTY: begin
               if (load) begin
                  state_q <= ST_REQ;
               end
            end
            ST_REQ: begin
               if (rsp_ack_i) begin
                  state_q <= ST_DROP;
               end
            end
            // Req is low, wait for the host to release ack
            ST_DROP: begin
               if (!rsp_ack_i) begin
                  state_q <= ST_EMPTY;
               end
            end
            default: begin
               state_q <= ST_EMPTY;
            end
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (load) begin
         rdata_q <= res_rdata_i;
         resp_q  <= res_resp_i;
      end
   end

   assign rsp_req_o   = (state_q == ST_REQ);
   assign rsp_rdata_o = rdata_q;
   assign rsp_resp_o  = resp_q;

   // The engine must hold its B/R ready while this register is busy
   a_no_overrun: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      res_valid_i |-> res_ready_o);

endmodule

/* verilog/axi_xfer_engine.sv */
// One AXI4-Lite transaction at a time; no IDs or bursts, and write results carry zero rdata
`timescale 1ns/10ps
`include "rot_cfg.svh"

module axi_xfer_engine import rot_pkg::*; (
   input  logic                     clk_i,
   input  logic                     rst_n_i,
   // Command FIFO head
   input  logic                     cmd_valid_i,
   input  rot_op_e                  cmd_op_i,
   input  logic [`ROT_ADDR_W-1:0]   cmd_addr_i,
   input  logic [`ROT_DATA_W-1:0]   cmd_wdata_i,
   output logic                     cmd_pop_o,
   // Entropy source
   input  logic [`ROT_DATA_W-1:0]   rnd_word_i,
   output logic                     rnd_take_o,
   // Result to the response side
   output logic                     res_valid_o,
   output logic [`ROT_DATA_W-1:0]   res_rdata_o,
   output rot_resp_e                res_resp_o,
   input  logic                     res_ready_i,
   // AW channel
   output logic [`ROT_ADDR_W-1:0]   aw_addr_o,
   output logic                     aw_valid_o,
   input  logic                     aw_ready_i,
   // W channel
   output logic [`ROT_DATA_W-1:0]   w_data_o,
   output logic [`ROT_DATA_W/8-1:0] w_strb_o,
   output logic                     w_valid_o,
   input  logic                     w_ready_i,
   // B channel
   input  logic [1:0]               b_resp_i,
   input  logic                     b_valid_i,
   output logic                     b_ready_o,
   // AR channel
   output logic [`ROT_ADDR_W-1:0]   ar_addr_o,
   output logic                     ar_valid_o,
   input  logic                     ar_ready_i,
   // R channel
   input  logic [`ROT_DATA_W-1:0]   r_data_i,
   input  logic [1:0]               r_resp_i,
   input  logic                     r_valid_i,
   output logic                     r_ready_o
);

   localparam logic [1:0] ST_IDLE = 2'd0;
   localparam logic [1:0] ST_ADDR = 2'd1;
   localparam logic [1:0] ST_RESP = 2'd2;

   logic [1:0]             state_q;
   rot_op_e                op_q;
   logic [`ROT_ADDR_W-1:0] addr_q;
   logic [`ROT_DATA_W-1:0] wdata_q;
   logic                   aw_valid_q;
   logic                   w_valid_q;
   logic                   ar_valid_q;
   logic                   is_write;
   logic                   aw_done;
   logic                   w_done;
   logic                   ar_done;
   logic                   b_beat;
   logic                   r_beat;

   assign cmd_pop_o  = (state_q == ST_IDLE) && cmd_valid_i;
   assign rnd_take_o = cmd_pop_o && (cmd_op_i == OP_WRITE_RND);
   assign is_write   = (op_q != OP_READ);

   // Channel finished earlier or accepted this cycle
   assign aw_done = !aw_valid_q || aw_ready_i;
   assign w_done  = !w_valid_q || w_ready_i;
   assign ar_done = !ar_valid_q || ar_ready_i;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q    <= ST_IDLE;
         aw_valid_q <= 1'b0;
         w_valid_q  <= 1'b0;
         ar_valid_q <= 1'b0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (cmd_valid_i) begin
                  state_q    <= ST_ADDR;
                  aw_valid_q <= (cmd_op_i != OP_READ);
                  w_valid_q  <= (cmd_op_i != OP_READ);
                  ar_valid_q <= (cmd_op_i == OP_READ);
               end
            end
            ST_ADDR: begin
               if (aw_ready_i) begin
                  aw_valid_q <= 1'b0;
               end
               if (w_ready_i) begin
                  w_valid_q <= 1'b0;
               end
               if (ar_ready_i) begin
                  ar_valid_q <= 1'b0;
               end
               if (is_write ? (aw_done && w_done) : ar_done) begin
                  state_q <= ST_RESP;
               end
            end
            ST_RESP: begin
               if (b_beat || r_beat) begin
                  state_q <= ST_IDLE;
               end
            end
            default: begin
               state_q <= ST_IDLE;
            end
         endcase
      end
   end

   // Random writes take the LFSR word seen in the pop cycle
   always_ff @(posedge clk_i) begin
      if (cmd_pop_o) begin
         op_q    <= cmd_op_i;
         addr_q  <= cmd_addr_i;
         wdata_q <= (cmd_op_i == OP_WRITE_RND) ? rnd_word_i : cmd_wdata_i;
      end
   end

   assign aw_addr_o  = addr_q;
   assign aw_valid_o = aw_valid_q;
   assign w_data_o   = wdata_q;
   assign w_strb_o   = '1;
   assign w_valid_o  = w_valid_q;
   assign ar_addr_o  = addr_q;
   assign ar_valid_o = ar_valid_q;

   // Response side full stalls the bus here
   assign b_ready_o = (state_q == ST_RESP) && is_write && res_ready_i;
   assign r_ready_o = (state_q == ST_RESP) && !is_write && res_ready_i;
   assign b_beat    = b_valid_i && b_ready_o;
   assign r_beat    = r_valid_i && r_ready_o;

   assign res_valid_o = b_beat || r_beat;
   assign res_resp_o  = r_beat ? rot_resp_e'(r_resp_i) : rot_resp_e'(b_resp_i);
   // Failed reads return zero whatever the slave drives
   assign res_rdata_o = (r_beat && (r_resp_i == RESP_OKAY)) ? r_data_i : '0;

   a_aw_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_addr_o));

   a_w_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_data_o));

   a_ar_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o));

endmodule

/* verilog/entropy_lfsr.sv */
// Not a secure RNG; word 0 is the seed and each rnd_take_i moves to the next word
`timescale 1ns/10ps
`include "rot_cfg.svh"

module entropy_lfsr (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  logic                   rnd_take_i,
   output logic [`ROT_DATA_W-1:0] rnd_word_o
);

   // Right-shifting Galois form of x^32+x^22+x^2+x+1
   localparam logic [31:0] TAPS = 32'h8020_0003;

   logic [31:0] lfsr_q;
   logic [31:0] lfsr_next;

   // Feedback applied when the bit shifted out is one
   assign lfsr_next = {1'b0, lfsr_q[31:1]} ^ (lfsr_q[0] ? TAPS : 32'h0);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         lfsr_q <= `ROT_LFSR_SEED;
      end else if (rnd_take_i) begin
         lfsr_q <= lfsr_next;
      end
   end

   assign rnd_word_o = lfsr_q;

   // A zero state would lock the sequence up for good
   a_never_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      lfsr_q != '0);

endmodule

/* verilog/cmd_intake.sv */
// Host must keep op, addr and wdata stable while cmd_req_i is high and wait for ack to drop
`timescale 1ns/10ps
`include "rot_cfg.svh"

module cmd_intake import rot_pkg::*; (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  logic                   cmd_req_i,
   input  rot_op_e                cmd_op_i,
   input  logic [`ROT_ADDR_W-1:0] cmd_addr_i,
   input  logic [`ROT_DATA_W-1:0] cmd_wdata_i,
   output logic                   cmd_ack_o,
   output logic                   cmd_valid_o,
   output rot_op_e                cmd_op_o,
   output logic [`ROT_ADDR_W-1:0] cmd_addr_o,
   output logic [`ROT_DATA_W-1:0] cmd_wdata_o,
   input  logic                   cmd_pop_i
);

   localparam int DEPTH = `ROT_CMD_DEPTH;
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   localparam logic [1:0] ST_IDLE = 2'd0;
   localparam logic [1:0] ST_WAIT = 2'd1;
   localparam logic [1:0] ST_ACK  = 2'd2;

   logic                   req_q;
   logic                   req_rise;
   logic [1:0]             state_q;
   logic                   push;
   logic                   full;
   logic [PTR_W-1:0]       wr_ptr_q;
   logic [PTR_W-1:0]       rd_ptr_q;
   logic [CNT_W-1:0]       count_q;
   rot_op_e                op_mem    [DEPTH];
   logic [`ROT_ADDR_W-1:0] addr_mem  [DEPTH];
   logic [`ROT_DATA_W-1:0] wdata_mem [DEPTH];

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   // Edge detector on the host request
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         req_q <= 1'b0;
      end else begin
         req_q <= cmd_req_i;
      end
   end

   assign req_rise = cmd_req_i & ~req_q;
   assign full     = (count_q == CNT_W'(DEPTH));

   // Capture on the edge, or later once a slot frees up
   assign push = ((state_q == ST_IDLE) && req_rise && !full) ||
                 ((state_q == ST_WAIT) && !full);

   // Ack phase
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q <= ST_IDLE;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (req_rise) begin
                  state_q <= full ? ST_WAIT : ST_ACK;
               end
            end
            ST_WAIT: begin
               if (!full) begin
                  state_q <= ST_ACK;
               end
            end
            ST_ACK: begin
               if (!cmd_req_i) begin
                  state_q <= ST_IDLE;
               end
            end
            default: begin
               state_q <= ST_IDLE;
            end
         endcase
      end
   end

   assign cmd_ack_o = (state_q == ST_ACK);

   // Circular FIFO pointers and fill level
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= ptr_inc(wr_ptr_q);
         end
         if (cmd_pop_i) begin
            rd_ptr_q <= ptr_inc(rd_ptr_q);
         end
         case ({push, cmd_pop_i})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (push) begin
         op_mem[wr_ptr_q]    <= cmd_op_i;
         addr_mem[wr_ptr_q]  <= cmd_addr_i;
         wdata_mem[wr_ptr_q] <= cmd_wdata_i;
      end
   end

   assign cmd_valid_o = (count_q != '0);
   assign cmd_op_o    = op_mem[rd_ptr_q];
   assign cmd_addr_o  = addr_mem[rd_ptr_q];
   assign cmd_wdata_o = wdata_mem[rd_ptr_q];

   // A push into a full FIFO would drive the fill level past the depth
   a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      count_q <= CNT_W'(DEPTH));

   // The engine only pops what it has seen
   a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      cmd_pop_i |-> cmd_valid_o);

endmodule

/* verilog/rot_pkg.sv */
// Opcode and response encodings only; EXOKAY and DECERR are not modelled by the wrapper
`include "rot_cfg.svh"

package rot_pkg;

   // Host command opcodes
   // OP_WRITE_RND stores the next LFSR word and ignores the host write data
   typedef enum logic [1:0] {
      OP_READ      = 2'b00,
      OP_WRITE     = 2'b01,
      OP_WRITE_RND = 2'b10
   } rot_op_e;

   // Same values as AXI BRESP and RRESP
   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_SLVERR = 2'b10
   } rot_resp_e;

endpackage

/* verilog/rot_cfg.svh */
// Widths are fixed at 32 bits and ROT_ERR_BASE is honoured by the memory model only
`ifndef ROT_CFG_SVH
`define ROT_CFG_SVH

// Bus widths
`define ROT_ADDR_W    32
`define ROT_DATA_W    32

// Command FIFO entries
`define ROT_CMD_DEPTH 2

// Nonzero reset value of the entropy LFSR
`define ROT_LFSR_SEED 32'h1D87_2F5B

// Memory model answers SLVERR from this address upward
`define ROT_ERR_BASE  32'hF000_0000

`endif
